/* logic/arb_pkg.sv */
// Arbiter shared types and widths

package arb_pkg;

  localparam int num_req    = 4;
  localparam int id_w       = $clog2(num_req);
  localparam int rand_sel_w = 2;
  localparam int mode_w     = 3;

  // Arbitration schemes
  typedef enum logic [mode_w-1:0] {
    mode_prio0       = 3'd0,
    mode_prio1       = 3'd1,
    mode_prio2       = 3'd2,
    mode_prio3       = 3'd3,
    mode_round_robin = 3'd4,
    mode_random      = 3'd5,
    mode_off         = 3'd6  // Grants nothing
  } arb_mode_e;

  // Configuration write from software
  typedef struct packed {
    logic              valid;  // One-cycle strobe
    logic [mode_w-1:0] mode;   // Raw code, 7 is illegal
  } cfg_wr_t;

  // Registered grant
  typedef struct packed {
    logic               valid;
    logic [id_w-1:0]    id;
    logic [num_req-1:0] onehot;
  } grant_t;

endpackage

/* logic/pn_seq_gen.sv */
// Random priority LFSR

`timescale 1ns/1ps

module pn_seq_gen (
  input  logic                           clk,
  input  logic                           rst_n,
  output logic [arb_pkg::rand_sel_w-1:0] rand_sel
);

  logic s1;
  logic s2;
  logic s3;
  logic fb;

  assign fb = s1 ^ s3;  // Period 7 feedback

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1 <= 1'b1;  // Nonzero seed
      s2 <= 1'b0;
      s3 <= 1'b0;
    end else begin
      s1 <= fb;
      s2 <= s1;
      s3 <= s2;
    end
  end

  // Two oldest stages pick the favoured requester
  assign rand_sel = {s3, s2};

endmodule

/* logic/arb_cfg_regs.sv */
// Arbitration scheme register

`timescale 1ns/1ps

module arb_cfg_regs (
  input  logic               clk,
  input  logic               rst_n,
  input  arb_pkg::cfg_wr_t   cfg,
  output arb_pkg::arb_mode_e mode
);

  import arb_pkg::*;

  arb_mode_e wr_mode;
  arb_mode_e mode_next;

  // Map raw codes onto legal schemes
  function automatic arb_mode_e filter_mode(input logic [mode_w-1:0] raw);
    arb_mode_e m;
    case (raw)
      mode_prio0,
      mode_prio1,
      mode_prio2,
      mode_prio3,
      mode_round_robin,
      mode_random: m = arb_mode_e'(raw);
      default:     m = mode_off;  // Code 6 and the illegal 7
    endcase
    return m;
  endfunction

  assign wr_mode = filter_mode(cfg.mode);

  always_comb begin
    mode_next = mode;  // Hold between writes
    if (cfg.valid) begin
      mode_next = wr_mode;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mode <= mode_prio0;
    end else begin
      mode <= mode_next;
    end
  end

endmodule

/* logic/multi_arbiter.sv */
// Four-way arbiter with switchable schemes
// Fixed priority, round robin and LFSR-driven random

`timescale 1ns/1ps

module multi_arbiter (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic [arb_pkg::num_req-1:0]    req,
  input  arb_pkg::arb_mode_e             mode,
  input  logic [arb_pkg::rand_sel_w-1:0] rand_sel,
  output arb_pkg::grant_t                grant
);

  import arb_pkg::*;

  // Candidate grants, one per scheme
  logic [num_req-1:0] gnt_prio [num_req];
  logic [num_req-1:0] gnt_rr;
  logic [num_req-1:0] gnt_rand;

  // Round robin search state
  logic [id_w-1:0]    rr_start;
  logic [id_w-1:0]    rr_idx;

  // Selected candidate before the register
  logic [num_req-1:0] gnt_next;
  logic [id_w-1:0]    id_next;
  grant_t             grant_next;

  // Favoured requester first, then the rest in ascending order
  function automatic logic [num_req-1:0] fixed_prio(
    input logic [num_req-1:0] r,
    input logic [id_w-1:0]    fav
  );
    logic [num_req-1:0] g;
    g = '0;
    if (r[fav]) begin
      g[fav] = 1'b1;
    end else begin
      for (int i = 0; i < num_req; i++) begin
        if (r[i] && (g == '0)) begin
          g[i] = 1'b1;
        end
      end
    end
    return g;
  endfunction

  // Fixed priority, one candidate per favoured index
  for (genvar k = 0; k < num_req; k++) begin : g_prio
    assign gnt_prio[k] = fixed_prio(req, id_w'(k));
  end

  // Random scheme reuses the fixed-priority rule
  assign gnt_rand = fixed_prio(req, rand_sel);

  // Idle grant behaves like holder 0
  always_comb begin
    if (grant.valid) begin
      rr_start = grant.id + 1'b1;  // Wraps past 3
    end else begin
      rr_start = id_w'(1);
    end
  end

  // Round robin, first requester at or after rr_start
  always_comb begin
    gnt_rr = '0;
    rr_idx = rr_start;
    for (int i = 0; i < num_req; i++) begin
      rr_idx = rr_start + id_w'(i);
      if (req[rr_idx] && (gnt_rr == '0)) begin
        gnt_rr[rr_idx] = 1'b1;
      end
    end
  end

  // Scheme select
  always_comb begin
    case (mode)
      mode_prio0:       gnt_next = gnt_prio[0];
      mode_prio1:       gnt_next = gnt_prio[1];
      mode_prio2:       gnt_next = gnt_prio[2];
      mode_prio3:       gnt_next = gnt_prio[3];
      mode_round_robin: gnt_next = gnt_rr;
      mode_random:      gnt_next = gnt_rand;
      mode_off:         gnt_next = '0;
      default:          gnt_next = '0;
    endcase
  end

  // One-hot to index
  always_comb begin
    id_next = '0;
    for (int i = 0; i < num_req; i++) begin
      if (gnt_next[i]) begin
        id_next = id_w'(i);
      end
    end
  end

  assign grant_next.valid  = |gnt_next;
  assign grant_next.id     = id_next;
  assign grant_next.onehot = gnt_next;

  // Grant lands one cycle after the request
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      grant <= '0;
    end else begin
      grant <= grant_next;
    end
  end

endmodule

/* logic/arb_top.sv */
// Multi-scheme arbiter top level

`timescale 1ns/1ps

module arb_top (
  input  logic                        clk,
  input  logic                        rst_n,
  input  arb_pkg::cfg_wr_t            cfg,
  input  logic [arb_pkg::num_req-1:0] req,
  output arb_pkg::grant_t             grant,
  output arb_pkg::arb_mode_e          mode
);

  import arb_pkg::*;

  logic [rand_sel_w-1:0] rand_sel;  // Favoured index for random scheme

  // Active scheme, written by software
  arb_cfg_regs u_cfg_regs (
    .clk   (clk),
    .rst_n (rst_n),
    .cfg   (cfg),
    .mode  (mode)
  );

  pn_seq_gen u_pn_seq_gen (
    .clk      (clk),
    .rst_n    (rst_n),
    .rand_sel (rand_sel)
  );

  multi_arbiter u_multi_arbiter (
    .clk      (clk),
    .rst_n    (rst_n),
    .req      (req),
    .mode     (mode),
    .rand_sel (rand_sel),
    .grant    (grant)
  );

endmodule

/* tests/multi_arbiter_asserts.sv */
// Grant legality checks

`timescale 1ns/1ps

module multi_arbiter_asserts (
  input logic                        clk,
  input logic                        rst_n,
  input logic [arb_pkg::num_req-1:0] req,
  input arb_pkg::arb_mode_e          mode,
  input arb_pkg::grant_t             grant
);

  import arb_pkg::*;

  int unsigned fail_count = 0;  // Count of failed assertions

  a_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(grant.onehot))
    else begin
      $error("grant vector has more than one bit set: %b", grant.onehot);
      fail_count++;
    end

  // Each winner was requesting at the sampling edge
  a_requested: assert property (@(posedge clk) disable iff (!rst_n)
    (grant.onehot & ~$past(req)) == '0)
    else begin
      $error("grant %b given without a request", grant.onehot);
      fail_count++;
    end

  a_valid: assert property (@(posedge clk) disable iff (!rst_n)
    grant.valid == (|grant.onehot))
    else begin
      $error("grant valid does not match the grant vector");
      fail_count++;
    end

  a_off: assert property (@(posedge clk) disable iff (!rst_n)
    (mode == mode_off) |=> (grant.onehot == '0))
    else begin
      $error("grant given after a cycle in mode_off");
      fail_count++;
    end

endmodule

bind multi_arbiter multi_arbiter_asserts u_asserts (
  .clk   (clk),
  .rst_n (rst_n),
  .req   (req),
  .mode  (mode),
  .grant (grant)
);

/* tests/arb_top_tb.sv */
// Multi-scheme arbiter testbench
// Table driven, with reference models for the mode, the LFSR and the grant

`timescale 1ns/1ps

module arb_top_tb;

  import arb_pkg::*;

  localparam int          reset_cycles = 4;
  localparam int          slack_cycles = 20;
  localparam logic [31:0] lcg_seed     = 32'h552a70c3;

  // One table row, applied for one cycle
  typedef struct packed {
    logic [2:0] test_id;
    logic       cfg_valid;
    logic [2:0] cfg_mode;
    logic [3:0] req;
  } row_t;

  // Reference LFSR stages
  typedef struct packed {
    logic s1;
    logic s2;
    logic s3;
  } lfsr_t;

  logic               clk;
  logic               rst_n;
  cfg_wr_t            cfg;
  logic [num_req-1:0] req;
  grant_t             grant;
  arb_mode_e          mode;

  row_t        rows[$];
  string       test_name [5];
  logic [31:0] lcg_state;
  int          cycles;
  int          cycle_limit;
  int          test_checks;
  int          test_errors;
  int          tests_passed;
  int          tests_failed;
  int          total_errors;

  // Reference state
  lfsr_t     lfsr_model;
  arb_mode_e mode_model;
  grant_t    prev_grant;
  grant_t    exp_grant;

  arb_top dut (
    .clk   (clk),
    .rst_n (rst_n),
    .cfg   (cfg),
    .req   (req),
    .grant (grant),
    .mode  (mode)
  );

  always #20 clk = ~clk;  // 40 ns period

  always @(posedge clk) begin
    cycles++;
    if (cycle_limit > 0 && cycles > cycle_limit) begin
      $display("Timeout: the test table did not finish within %0d cycles", cycle_limit);
      $display("** FAIL **");
      $finish;
    end
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // s1 gets s1^s3, the others shift along
  function automatic lfsr_t lfsr_step(input lfsr_t s);
    lfsr_t n;
    n.s1 = s.s1 ^ s.s3;
    n.s2 = s.s1;
    n.s3 = s.s2;
    return n;
  endfunction

  function automatic arb_mode_e filter_code(input logic [2:0] code);
    if (code == 3'd7) begin
      return mode_off;  // Illegal code
    end
    return arb_mode_e'(code);
  endfunction

  // Favoured requester, else lowest index
  function automatic int fav_winner(input logic [3:0] r, input int fav);
    if (r[fav]) begin
      return fav;
    end
    for (int i = 0; i < num_req; i++) begin
      if (r[i]) begin
        return i;
      end
    end
    return -1;
  endfunction

  function automatic int rr_winner(input logic [3:0] r, input grant_t held);
    int start;
    int idx;
    start = held.valid ? (int'(held.id) + 1) % num_req : 1;  // Idle acts as holder 0
    for (int i = 0; i < num_req; i++) begin
      idx = (start + i) % num_req;
      if (r[idx]) begin
        return idx;
      end
    end
    return -1;
  endfunction

  function automatic grant_t expect_grant(input logic [3:0] r, input arb_mode_e m,
                                          input lfsr_t s, input grant_t held);
    int     winner;
    grant_t g;
    case (m)
      mode_prio0, mode_prio1, mode_prio2, mode_prio3: winner = fav_winner(r, int'(m));
      mode_round_robin: winner = rr_winner(r, held);
      mode_random:      winner = fav_winner(r, int'({s.s3, s.s2}));
      default:          winner = -1;
    endcase
    g = '0;
    if (winner >= 0) begin
      g.valid  = 1'b1;
      g.id     = winner[1:0];
      g.onehot = 4'b0001 << winner;
    end
    return g;
  endfunction

  task automatic add_row(input int id, input logic v, input logic [2:0] m, input logic [3:0] r);
    row_t row;
    row.test_id   = 3'(id);
    row.cfg_valid = v;
    row.cfg_mode  = m;
    row.req       = r;
    rows.push_back(row);
  endtask

  task automatic build_table();
    logic [3:0] r;
    add_row(0, 1'b0, 3'd0, 4'b1010);  // Reset mode is prio0
    add_row(0, 1'b0, 3'd0, 4'b0110);
    for (int k = 0; k < num_req; k++) begin
      add_row(1, 1'b1, 3'(k), 4'b0000);
      for (int v = 0; v < 16; v++) begin
        add_row(1, 1'b0, 3'(k), 4'(v));
      end
    end
    add_row(2, 1'b1, 3'd4, 4'b0000);  // Leaves the grant idle
    repeat (8) begin
      add_row(2, 1'b0, 3'd4, 4'b1111);
    end
    repeat (12) begin
      lcg_state = lcg_next(lcg_state);
      r = lcg_state[31:28] & lcg_state[19:16];  // Sparse vectors
      add_row(2, 1'b0, 3'd4, r);
    end
    lcg_state = lcg_next(lcg_state);
    add_row(3, 1'b1, 3'd5, lcg_state[31:28]);
    repeat (16) begin
      lcg_state = lcg_next(lcg_state);
      add_row(3, 1'b0, 3'd5, lcg_state[31:28]);
    end
    // Mode writes, including the illegal code
    add_row(4, 1'b1, 3'd7, 4'b1111);
    repeat (3) begin
      add_row(4, 1'b0, 3'd0, 4'b1111);
    end
    add_row(4, 1'b1, 3'd2, 4'b1111);
    add_row(4, 1'b0, 3'd5, 4'b1111);  // No strobe, mode must hold
    add_row(4, 1'b0, 3'd1, 4'b0011);
    add_row(4, 1'b1, 3'd6, 4'b0100);
    add_row(4, 1'b0, 3'd0, 4'b0100);
    add_row(4, 1'b1, 3'd3, 4'b1001);
    add_row(4, 1'b0, 3'd7, 4'b1001);
    add_row(4, 1'b0, 3'd0, 4'b0000);
  endtask

  task automatic check_outputs();
    test_checks++;
    assert (grant == exp_grant) else begin
      $display("[ERROR] %t grant expected %h actual %h", $time, exp_grant, grant);
      test_errors++;
    end
    assert (mode == mode_model) else begin
      $display("[ERROR] %t mode expected %0d actual %0d", $time, mode_model, mode);
      test_errors++;
    end
  endtask

  task automatic close_test(input int id);
    total_errors += test_errors;
    if (test_errors == 0) begin
      tests_passed++;
    end else begin
      tests_failed++;
    end
    $display("Test %0d (%s): %0d checks, %0d errors", id, test_name[id], test_checks,
             test_errors);
    test_checks = 0;
    test_errors = 0;
  endtask

  initial begin
    row_t row;
    int   cur_test;
    int   bound_fails;
    $timeformat(-9, 0, " ns", 0);
    clk          = 1'b0;
    rst_n        = 1'b0;
    cfg          = '0;
    req          = '0;
    cycles       = 0;
    cycle_limit  = 0;
    test_checks  = 0;
    test_errors  = 0;
    tests_passed = 0;
    tests_failed = 0;
    total_errors = 0;
    test_name[0] = "reset state";
    test_name[1] = "fixed priorities";
    test_name[2] = "round robin";
    test_name[3] = "random scheme";
    test_name[4] = "mode writes";
    lcg_state    = lcg_seed;
    build_table();
    cycle_limit  = reset_cycles + rows.size() + slack_cycles;

    lfsr_model = '{s1: 1'b1, s2: 1'b0, s3: 1'b0};
    mode_model = mode_prio0;
    prev_grant = '0;
    exp_grant  = '0;

    repeat (reset_cycles) @(posedge clk);
    #2;
    rst_n = 1'b1;
    check_outputs();  // Reset values

    cur_test = 0;
    foreach (rows[i]) begin
      row = rows[i];
      if (int'(row.test_id) != cur_test) begin
        close_test(cur_test);
        cur_test = int'(row.test_id);
      end
      cfg.valid = row.cfg_valid;
      cfg.mode  = row.cfg_mode;
      req       = row.req;
      @(posedge clk);
      // Grant uses the mode and LFSR state from before this edge
      exp_grant = expect_grant(row.req, mode_model, lfsr_model, prev_grant);
      if (row.cfg_valid) begin
        mode_model = filter_code(row.cfg_mode);
      end
      lfsr_model = lfsr_step(lfsr_model);
      prev_grant = exp_grant;
      #2;
      check_outputs();
    end
    close_test(cur_test);
    cfg = '0;
    req = '0;

    bound_fails = dut.u_multi_arbiter.u_asserts.fail_count;
    if (bound_fails != 0) begin
      $display("Bound grant assertions failed %0d times", bound_fails);
    end
    $display("Summary: %0d tests passed, %0d tests failed, %0d check errors", tests_passed,
             tests_failed, total_errors);
    if (tests_failed == 0 && bound_fails == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

/* files.f */
logic/arb_pkg.sv
logic/pn_seq_gen.sv
logic/arb_cfg_regs.sv
logic/multi_arbiter.sv
logic/arb_top.sv
tests/multi_arbiter_asserts.sv
tests/arb_top_tb.sv

/* Bender.yml */
package:
  name: arb_top

sources:
  - logic/arb_pkg.sv
  - logic/pn_seq_gen.sv
  - logic/arb_cfg_regs.sv
  - logic/multi_arbiter.sv
  - logic/arb_top.sv
  - target: test
    files:
      - tests/multi_arbiter_asserts.sv
      - tests/arb_top_tb.sv
